// ==== ntm_cosh_tb_util.svh ====
// Testbench helpers for the vector cosh accelerator
// Included inside the testbench module body, so the tasks drive its bus signals.
// Holds the LFSR, the series reference model and the Wishbone master tasks
`ifndef NTM_COSH_TB_UTIL_SVH
`define NTM_COSH_TB_UTIL_SVH

////////////////////////////////////////////////////////////////////////////
// Random operands
////////////////////////////////////////////////////////////////////////////

// Galois feedback mask, x^32 + x^30 + x^26 + x^25 + 1
localparam logic [31:0] LFSR_TAPS = 32'hA300_0000;

logic [31:0] lfsr = 32'd25244;

// One LFSR step per bit taken
function automatic data_t rand_bits(input int nbits);
  data_t v;
  int    i;
  v = '0;
  for (i = 0; i < nbits; i++) begin
    lfsr = lfsr[0] ? ((lfsr >> 1) ^ LFSR_TAPS) : (lfsr >> 1);
    v    = {v[DATA_SIZE-2:0], lfsr[0]};
  end
  return v;
endfunction

////////////////////////////////////////////////////////////////////////////
// Reference model
////////////////////////////////////////////////////////////////////////////

// Truncated cosh series in modular integer arithmetic
function automatic data_t cosh_model(input data_t x, input data_t m);
  longint unsigned mm;
  longint unsigned sq;
  longint unsigned term;
  longint unsigned sum;
  int              k;
  mm   = m;
  sq   = ((x % mm) * (x % mm)) % mm;
  // 1 mod M starts both the term and the sum
  term = 1 % mm;
  sum  = term;
  for (k = 1; k < TERMS; k++) begin
    term = ((term * sq) % mm) / longint'((2 * k - 1) * (2 * k));
    sum  = (sum + term) % mm;
  end
  return data_t'(sum);
endfunction

////////////////////////////////////////////////////////////////////////////
// Wishbone master, called 1 ns after a rising edge
////////////////////////////////////////////////////////////////////////////

task automatic next_cycle();
  @(posedge CLK);
  #1;
endtask

task automatic idle(input int n);
  repeat (n) next_cycle();
endtask

// One classic cycle, held until ack, released after the ack cycle ends
task automatic bus_access(input logic we, input wb_adr_t adr, input data_t wdat,
                          output data_t rdat);
  int n;
  bit seen;
  wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
  n      = 0;
  seen   = 1'b0;
  while (!seen && n < BUS_TIMEOUT) begin
    next_cycle();
    n++;
    seen = wb_rsp.ack;
  end
  rdat = wb_rsp.dat;
  if (!seen) begin
    timeouts++;
    $display("timeout: no acknowledge from the slave at address %0d", adr);
  end
  // Slave captures write data on this edge
  next_cycle();
  wb_req = '0;
  if (seen) begin
    check_value("ack_latency", data_t'(n), data_t'(1));
    // Ack is a single-cycle pulse
    check_value("ack", data_t'(wb_rsp.ack), '0);
  end
endtask

task automatic bus_write(input wb_adr_t adr, input data_t wdat);
  data_t unused;
  bus_access(1'b1, adr, wdat, unused);
endtask

task automatic bus_read(input wb_adr_t adr, output data_t rdat);
  bus_access(1'b0, adr, '0, rdat);
endtask

`endif

// ==== ntm_cosh_tb.sv ====
// Testbench for the Wishbone vector cosh accelerator
// Drives register accesses through the slave port and compares every
// result against the series model. Ends with one summary line.
`timescale 1ns/1ps

module ntm_cosh_tb import ntm_pkg::*; ();

  // Cycles allowed for one ack, and CTRL polls allowed for one run
  localparam int BUS_TIMEOUT  = 8;
  localparam int DONE_TIMEOUT = 2000;

  logic    CLK;
  logic    RST;
  wb_req_t wb_req;
  wb_rsp_t wb_rsp;

  // Bookkeeping
  int    checks;
  int    errors;
  int    timeouts;
  int    done_rises;
  logic  done_q;
  data_t vec[$];

  task automatic check_value(input string name, input data_t got, input data_t exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("mismatch %s: got 0x%08h, expected 0x%08h", name, got, exp);
    end
  endtask

  `include "ntm_cosh_tb_util.svh"

  ntm_cosh_wb_top dut0 (
    .CLK    (CLK),
    .RST    (RST),
    .WB_REQ (wb_req),
    .WB_RSP (wb_rsp)
  );

  initial begin
    CLK = 1'b0;
    forever #2 CLK = ~CLK;
  end

  // Counts rising edges of the done flag
  initial begin
    done_rises = 0;
    done_q     = 1'b0;
    forever begin
      @(negedge CLK);
      if (dut0.done && !done_q) begin
        done_rises++;
      end
      done_q = dut0.done;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Run helpers
  ////////////////////////////////////////////////////////////////////////////

  // Load M, length and operands from vec, then start
  task automatic run_vector(input data_t m);
    data_t rd;
    int    i;
    bus_write(REG_MODULO, m);
    bus_write(REG_SIZE, data_t'(vec.size() - 1));
    // Both registers read back as written
    bus_read(REG_MODULO, rd);
    check_value("modulo", rd, m);
    bus_read(REG_SIZE, rd);
    check_value("size", rd, data_t'(vec.size() - 1));
    for (i = 0; i < vec.size(); i++) begin
      bus_write(REG_DATA_IN, vec[i]);
    end
    bus_write(REG_CTRL, data_t'(1));
  endtask

  task automatic wait_done();
    data_t rd;
    int    n;
    n  = 0;
    rd = '0;
    while (!rd[1] && n < DONE_TIMEOUT) begin
      bus_read(REG_CTRL, rd);
      n++;
    end
    if (!rd[1]) begin
      timeouts++;
      $display("timeout: done flag never rose after start");
    end
  endtask

  // Poll the result count until one result is buffered
  task automatic wait_first_result();
    data_t rd;
    int    n;
    n  = 0;
    rd = '0;
    while (rd == '0 && n < DONE_TIMEOUT) begin
      bus_read(REG_STATUS, rd);
      n++;
    end
    if (rd == '0) begin
      timeouts++;
      $display("timeout: no result was buffered during the run");
    end
  endtask

  // Count, results in order, then an empty buffer
  task automatic check_results(input data_t m);
    data_t rd;
    int    i;
    bus_read(REG_STATUS, rd);
    check_value("status", rd, data_t'(vec.size()));
    for (i = 0; i < vec.size(); i++) begin
      bus_read(REG_DATA_OUT, rd);
      check_value("data_out", rd, cosh_model(vec[i], m));
    end
    bus_read(REG_DATA_OUT, rd);
    check_value("data_out_empty", rd, '0);
    bus_read(REG_STATUS, rd);
    check_value("status_drained", rd, '0);
  endtask

  task automatic fill_random(input int n);
    vec.delete();
    repeat (n) vec.push_back(rand_bits(DATA_SIZE));
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Scenarios
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    data_t rd;
    data_t m;
    int    base;
    int    i;
    RST      = 1'b1;
    wb_req   = '0;
    checks   = 0;
    errors   = 0;
    timeouts = 0;
    repeat (16) @(posedge CLK);
    #1;
    RST = 1'b0;
    next_cycle();

    // Idle state after reset
    bus_read(REG_CTRL, rd);
    check_value("ctrl", rd, '0);
    bus_read(REG_STATUS, rd);
    check_value("status", rd, '0);

    // Single elements with known values, cosh(0) is exactly 1
    vec = '{data_t'(0)};
    run_vector(data_t'(1000));
    wait_done();
    bus_read(REG_DATA_OUT, rd);
    check_value("data_out", rd, data_t'(1));
    vec = '{data_t'(1)};
    run_vector(data_t'(1000));
    wait_done();
    check_results(data_t'(1000));
    vec = '{data_t'(3)};
    run_vector(data_t'(1000));
    wait_done();
    check_results(data_t'(1000));

    // Full random vector
    m = rand_bits(DATA_SIZE);
    if (m == '0) begin
      m = data_t'(1);
    end
    fill_random(VEC_DEPTH);
    run_vector(m);
    wait_done();
    check_results(m);

    // Start while busy is ignored, before and after the first result
    m = rand_bits(16) | data_t'(1);
    fill_random(4);
    base = done_rises;
    run_vector(m);
    bus_read(REG_CTRL, rd);
    check_value("ctrl_busy", rd & data_t'(1), data_t'(1));
    bus_write(REG_CTRL, data_t'(1));
    wait_first_result();
    bus_write(REG_CTRL, data_t'(1));
    wait_done();
    idle(40);
    check_value("done_rises", data_t'(done_rises - base), data_t'(1));
    bus_read(REG_CTRL, rd);
    check_value("ctrl", rd, data_t'(2));
    check_results(m);

    // Modulus of one gives zero everywhere
    fill_random(3);
    run_vector(data_t'(1));
    wait_done();
    check_results(data_t'(1));

    // First run left partly unread, second run sees only its own results
    m = rand_bits(DATA_SIZE) | data_t'(1);
    fill_random(6);
    run_vector(m);
    wait_done();
    for (i = 0; i < 2; i++) begin
      bus_read(REG_DATA_OUT, rd);
      check_value("data_out", rd, cosh_model(vec[i], m));
    end
    m = (m >> 4) | data_t'(2);
    fill_random(3);
    run_vector(m);
    wait_done();
    check_results(m);

    $display("checks: %0d, mismatches: %0d, timeouts: %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// ==== ntm_cosh_wb_top.sv ====
// Wishbone classic slave around the vector cosh engine
// Holds the register file, input and output buffers and busy/done flags.
// Every access is acknowledged one cycle after cyc and stb are seen
`timescale 1ns/1ps

module ntm_cosh_wb_top import ntm_pkg::*; (
  input  logic    CLK,
  input  logic    RST,
  input  wb_req_t WB_REQ,
  output wb_rsp_t WB_RSP
);

  // Buffer pointers, 0 to VEC_DEPTH
  typedef logic [$clog2(VEC_DEPTH):0] ptr_t;

  ////////////////////////////////////////////////////////////////////////////
  // Signals
  ////////////////////////////////////////////////////////////////////////////

  // Bus
  logic  wb_ack;
  data_t wb_rdata;
  data_t rd_mux;
  logic  wb_sel;
  logic  wr_fire;
  logic  rd_fire;

  // Registers and flags
  data_t  modulo_reg;
  index_t size_reg;
  logic   busy;
  logic   done;
  logic   start;

  // Buffers
  data_t in_buf  [VEC_DEPTH];
  data_t out_buf [VEC_DEPTH];
  ptr_t  in_wr_ptr;
  ptr_t  out_wr_ptr;
  ptr_t  out_rd_ptr;
  ptr_t  out_count;
  logic  out_empty;

  // Engine
  logic   eng_ready;
  logic   eng_in_en;
  logic   eng_out_en;
  data_t  eng_out;
  index_t eng_index;

  assign wb_sel  = WB_REQ.cyc && WB_REQ.stb;
  // Side effects only on the ack cycle
  assign wr_fire = wb_sel && wb_ack && WB_REQ.we;
  assign rd_fire = wb_sel && wb_ack && !WB_REQ.we;

  // Unread results
  assign out_count = out_wr_ptr - out_rd_ptr;
  assign out_empty = (out_count == '0);

  // Element is in the buffer once the host has pushed it
  assign eng_in_en = (ptr_t'(eng_index) < in_wr_ptr);

  assign WB_RSP = '{ack: wb_ack, dat: wb_rdata};

  // Read decode
  always_comb begin
    case (WB_REQ.adr)
      REG_CTRL:     rd_mux = {30'b0, done, busy};
      REG_MODULO:   rd_mux = modulo_reg;
      REG_SIZE:     rd_mux = data_t'(size_reg);
      REG_DATA_OUT: rd_mux = out_empty ? '0 : out_buf[index_t'(out_rd_ptr)];
      REG_STATUS:   rd_mux = data_t'(out_count);
      default:      rd_mux = '0;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Control
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      wb_ack     <= 1'b0;
      modulo_reg <= '0;
      size_reg   <= '0;
      busy       <= 1'b0;
      done       <= 1'b0;
      start      <= 1'b0;
      in_wr_ptr  <= '0;
      out_wr_ptr <= '0;
      out_rd_ptr <= '0;
    end else begin
      // Single-cycle ack
      wb_ack <= wb_sel && !wb_ack;
      start  <= 1'b0;

      if (wr_fire) begin
        case (WB_REQ.adr)
          REG_CTRL: begin
            // Ignored while a run is active
            if (WB_REQ.dat[0] && !busy) begin
              start      <= 1'b1;
              busy       <= 1'b1;
              done       <= 1'b0;
              out_wr_ptr <= '0;
              out_rd_ptr <= '0;
            end
          end
          REG_MODULO: modulo_reg <= WB_REQ.dat;
          REG_SIZE:   size_reg   <= index_t'(WB_REQ.dat);
          REG_DATA_IN: begin
            if (in_wr_ptr < ptr_t'(VEC_DEPTH)) begin
              in_wr_ptr <= in_wr_ptr + 1'b1;
            end
          end
          default: begin
          end
        endcase
      end

      // Pop on a result read
      if (rd_fire && WB_REQ.adr == REG_DATA_OUT && !out_empty) begin
        out_rd_ptr <= out_rd_ptr + 1'b1;
      end

      if (eng_out_en) begin
        out_wr_ptr <= out_wr_ptr + 1'b1;
      end

      // Run finished, input buffer free for the next vector
      if (eng_ready) begin
        busy      <= 1'b0;
        done      <= 1'b1;
        in_wr_ptr <= '0;
      end
    end
  end

  // Read data and buffer storage
  always_ff @(posedge CLK) begin
    if (wb_sel && !wb_ack) begin
      wb_rdata <= rd_mux;
    end
    if (wr_fire && WB_REQ.adr == REG_DATA_IN && in_wr_ptr < ptr_t'(VEC_DEPTH)) begin
      in_buf[index_t'(in_wr_ptr)] <= WB_REQ.dat;
    end
    if (eng_out_en) begin
      out_buf[index_t'(out_wr_ptr)] <= eng_out;
    end
  end

  ntm_vector_cosh_function vector_cosh_function (
    .CLK             (CLK),
    .RST             (RST),
    .START           (start),
    .READY           (eng_ready),
    .DATA_IN_ENABLE  (eng_in_en),
    .DATA_OUT_ENABLE (eng_out_en),
    .MODULO_IN       (modulo_reg),
    .SIZE_IN         (size_reg),
    .DATA_IN         (in_buf[eng_index]),
    .DATA_OUT        (eng_out),
    .INDEX_OUT       (eng_index)
  );

endmodule

// ==== ntm_integer_divider.sv ====
// Sequential restoring divider, QUOTIENT_OUT = DIVIDEND_IN / DIVISOR_IN
// One quotient bit per cycle. The divisor is nonzero by construction.
// READY pulses DATA_SIZE+1 cycles after START
`timescale 1ns/1ps

module ntm_integer_divider import ntm_pkg::*; (
  input  logic  CLK,
  input  logic  RST,
  input  logic  START,
  input  data_t DIVIDEND_IN,
  input  data_t DIVISOR_IN,
  output logic  READY,
  output data_t QUOTIENT_OUT
);

  typedef logic [$clog2(DATA_SIZE):0] cnt_t;

  // Control
  logic busy;
  cnt_t count;

  // Partial remainder, shifting dividend/quotient, divisor
  data_t rem;
  data_t quo;
  data_t dvs;

  // Trial step
  logic [DATA_SIZE:0] shifted;
  logic               q_bit;
  data_t              rem_next;

  always_comb begin
    // Bring down the next dividend bit
    shifted  = {rem, quo[DATA_SIZE-1]};
    q_bit    = (shifted >= {1'b0, dvs});
    rem_next = shifted[DATA_SIZE-1:0];
    if (q_bit) begin
      // Keep the difference when the divisor fits
      rem_next = data_t'(shifted - {1'b0, dvs});
    end
  end

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      busy  <= 1'b0;
      count <= '0;
      READY <= 1'b0;
    end else begin
      READY <= 1'b0;
      if (START && !busy) begin
        busy  <= 1'b1;
        count <= '0;
      end else if (busy) begin
        count <= count + 1'b1;
        if (count == cnt_t'(DATA_SIZE-1)) begin
          busy  <= 1'b0;
          READY <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (START && !busy) begin
      rem <= '0;
      quo <= DIVIDEND_IN;
      dvs <= DIVISOR_IN;
    end else if (busy) begin
      rem <= rem_next;
      quo <= {quo[DATA_SIZE-2:0], q_bit};
      // Last bit, publish together with READY
      if (count == cnt_t'(DATA_SIZE-1)) begin
        QUOTIENT_OUT <= {quo[DATA_SIZE-2:0], q_bit};
      end
    end
  end

endmodule

// ==== ntm_mod_multiplier.sv ====
// Sequential modular multiplier, DATA_OUT = A_IN * B_IN mod MODULO_IN
// Scans B_IN from the MSB, one bit per cycle. A_IN must not exceed the modulus.
// READY pulses DATA_SIZE+2 cycles after START, with DATA_OUT valid and held
`timescale 1ns/1ps

module ntm_mod_multiplier import ntm_pkg::*; (
  input  logic  CLK,
  input  logic  RST,
  input  logic  START,
  input  data_t MODULO_IN,
  input  data_t A_IN,
  input  data_t B_IN,
  output logic  READY,
  output data_t DATA_OUT
);

  // Step counter, counts up to DATA_SIZE
  typedef logic [$clog2(DATA_SIZE):0] cnt_t;

  // Control
  logic busy;
  cnt_t count;

  // Operands, captured on START
  data_t m_reg;
  data_t a_reg;
  data_t b_reg;
  data_t acc;

  // One bit wider so 2*acc and the A addition cannot wrap
  logic [DATA_SIZE:0] dbl;
  logic [DATA_SIZE:0] sum;

  always_comb begin
    // Double, then bring back below M
    dbl = {acc, 1'b0};
    if (dbl >= {1'b0, m_reg}) begin
      dbl = dbl - {1'b0, m_reg};
    end
    // Add A for a set bit of B
    sum = dbl;
    if (b_reg[DATA_SIZE-1]) begin
      sum = dbl + {1'b0, a_reg};
    end
    // dbl < M and A <= M, so one subtraction is enough
    if (sum >= {1'b0, m_reg}) begin
      sum = sum - {1'b0, m_reg};
    end
  end

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      busy  <= 1'b0;
      count <= '0;
      READY <= 1'b0;
    end else begin
      READY <= 1'b0;
      if (START && !busy) begin
        busy  <= 1'b1;
        count <= '0;
      end else if (busy) begin
        if (count == cnt_t'(DATA_SIZE)) begin
          // All bits consumed, one cycle to publish
          busy  <= 1'b0;
          READY <= 1'b1;
        end else begin
          count <= count + 1'b1;
        end
      end
    end
  end

  // Datapath
  always_ff @(posedge CLK) begin
    if (START && !busy) begin
      m_reg <= MODULO_IN;
      a_reg <= A_IN;
      b_reg <= B_IN;
      acc   <= '0;
    end else if (busy) begin
      if (count == cnt_t'(DATA_SIZE)) begin
        DATA_OUT <= acc;
      end else begin
        acc   <= sum[DATA_SIZE-1:0];
        b_reg <= {b_reg[DATA_SIZE-2:0], 1'b0};
      end
    end
  end

endmodule

// ==== ntm_pkg.sv ====
// Shared definitions for the vector cosh accelerator
// Widths, operand typedefs, FSM encodings, Wishbone request and response
// structs and the register map. Imported by every RTL module.

package ntm_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////////////////////////////////////////

  // Operand width
  localparam int DATA_SIZE = 32;
  // Series terms, including the constant term
  localparam int TERMS = 4;
  // Buffer depth and longest vector
  localparam int VEC_DEPTH = 8;
  // Wishbone word address width
  localparam int ADDR_SIZE = 3;

  ////////////////////////////////////////////////////////////////////////////
  // Typedefs
  ////////////////////////////////////////////////////////////////////////////

  // Operands, moduli and results
  typedef logic [DATA_SIZE-1:0] data_t;
  // Element index within a vector
  typedef logic [2:0] index_t;
  // Word address on the slave port
  typedef logic [ADDR_SIZE-1:0] wb_adr_t;

  // Host to slave
  typedef struct packed {
    logic    cyc;
    logic    stb;
    logic    we;
    wb_adr_t adr;
    data_t   dat;
  } wb_req_t;

  // Slave to host
  typedef struct packed {
    logic  ack;
    data_t dat;
  } wb_rsp_t;

  // Vector controller FSM
  typedef enum logic [1:0] {
    STARTER,
    INPUT,
    ENDER
  } vec_state_t;

  // Scalar series FSM
  typedef enum logic [2:0] {
    IDLE,
    SQUARE,
    MULT,
    DIV,
    ACCUM,
    DONE
  } scal_state_t;

  ////////////////////////////////////////////////////////////////////////////
  // Register map, word addresses
  ////////////////////////////////////////////////////////////////////////////

  localparam wb_adr_t REG_CTRL     = 3'd0;
  localparam wb_adr_t REG_MODULO   = 3'd1;
  localparam wb_adr_t REG_SIZE     = 3'd2;
  localparam wb_adr_t REG_DATA_IN  = 3'd3;
  localparam wb_adr_t REG_DATA_OUT = 3'd4;
  localparam wb_adr_t REG_STATUS   = 3'd5;

endpackage

// ==== ntm_scalar_cosh_function.sv ====
// Scalar cosh of one operand, as a truncated series modulo MODULO_IN
// term_0 = 1 mod M, term_k = (term_(k-1) * x^2 mod M) / ((2k-1)(2k))
// DATA_OUT is the sum of TERMS terms mod M, valid while READY pulses
`timescale 1ns/1ps

module ntm_scalar_cosh_function import ntm_pkg::*; (
  input  logic  CLK,
  input  logic  RST,
  input  logic  START,
  output logic  READY,
  input  data_t MODULO_IN,
  input  data_t DATA_IN,
  output data_t DATA_OUT
);

  // Series step index, 1 to TERMS-1
  typedef logic [$clog2(TERMS):0] step_t;

  // FSM
  scal_state_t state;
  step_t       k;
  // First multiplier pass of SQUARE reduces x below M
  logic        reduce_pass;

  // Operands and series state
  data_t m_reg;
  data_t x_reg;
  data_t sq;
  data_t term;
  data_t sum;

  // Multiplier
  logic  mul_start;
  logic  mul_ready;
  data_t mul_a;
  data_t mul_b;
  data_t mul_out;

  // Divider
  logic  div_start;
  logic  div_ready;
  data_t div_coef;
  data_t div_out;

  // Sum plus term, one bit wider
  logic [DATA_SIZE:0] acc_sum;

  // Divisor (2k-1)(2k) for the current step
  assign div_coef = data_t'((2 * k - 1) * (2 * k));

  always_comb begin
    acc_sum = {1'b0, sum} + {1'b0, term};
    if (acc_sum >= {1'b0, m_reg}) begin
      acc_sum = acc_sum - {1'b0, m_reg};
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Control
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state       <= IDLE;
      k           <= '0;
      reduce_pass <= 1'b0;
      mul_start   <= 1'b0;
      div_start   <= 1'b0;
      READY       <= 1'b0;
    end else begin
      // Strobes last one cycle
      mul_start <= 1'b0;
      div_start <= 1'b0;
      READY     <= 1'b0;
      case (state)
        IDLE: begin
          if (START) begin
            // x * 1 mod M first
            k           <= step_t'(1);
            reduce_pass <= 1'b1;
            mul_start   <= 1'b1;
            state       <= SQUARE;
          end
        end
        SQUARE: begin
          if (mul_ready) begin
            mul_start   <= 1'b1;
            reduce_pass <= 1'b0;
            // Second pass gave x^2 mod M, start term_1
            if (!reduce_pass) begin
              state <= MULT;
            end
          end
        end
        MULT: begin
          if (mul_ready) begin
            div_start <= 1'b1;
            state     <= DIV;
          end
        end
        DIV: begin
          if (div_ready) begin
            state <= ACCUM;
          end
        end
        ACCUM: begin
          if (k == step_t'(TERMS-1)) begin
            state <= DONE;
          end else begin
            k         <= k + 1'b1;
            mul_start <= 1'b1;
            state     <= MULT;
          end
        end
        DONE: begin
          READY <= 1'b1;
          state <= IDLE;
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    case (state)
      IDLE: begin
        if (START) begin
          m_reg <= MODULO_IN;
          x_reg <= DATA_IN;
          // 1 mod M, which is 0 for M = 1
          term  <= (MODULO_IN == data_t'(1)) ? '0 : data_t'(1);
          sum   <= (MODULO_IN == data_t'(1)) ? '0 : data_t'(1);
          mul_a <= data_t'(1);
          mul_b <= DATA_IN;
        end
      end
      SQUARE: begin
        if (mul_ready) begin
          if (reduce_pass) begin
            // Reduced x times raw x
            mul_a <= mul_out;
            mul_b <= x_reg;
          end else begin
            sq    <= mul_out;
            mul_a <= term;
            mul_b <= mul_out;
          end
        end
      end
      DIV: begin
        if (div_ready) begin
          term <= div_out;
        end
      end
      ACCUM: begin
        sum   <= acc_sum[DATA_SIZE-1:0];
        mul_a <= term;
        mul_b <= sq;
      end
      DONE: begin
        DATA_OUT <= sum;
      end
      default: begin
      end
    endcase
  end

  ntm_mod_multiplier mod_multiplier (
    .CLK       (CLK),
    .RST       (RST),
    .START     (mul_start),
    .MODULO_IN (m_reg),
    .A_IN      (mul_a),
    .B_IN      (mul_b),
    .READY     (mul_ready),
    .DATA_OUT  (mul_out)
  );

  // Dividend is the held multiplier result
  ntm_integer_divider integer_divider (
    .CLK          (CLK),
    .RST          (RST),
    .START        (div_start),
    .DIVIDEND_IN  (mul_out),
    .DIVISOR_IN   (div_coef),
    .READY        (div_ready),
    .QUOTIENT_OUT (div_out)
  );

endmodule

// ==== ntm_vector_cosh_function.sv ====
// Vector cosh controller
// Walks elements 0 to SIZE_IN, one scalar cosh run per element.
// Each result comes out with DATA_OUT_ENABLE, the last one also with READY
`timescale 1ns/1ps

module ntm_vector_cosh_function import ntm_pkg::*; (
  input  logic   CLK,
  input  logic   RST,
  input  logic   START,
  output logic   READY,
  input  logic   DATA_IN_ENABLE,
  output logic   DATA_OUT_ENABLE,
  input  data_t  MODULO_IN,
  input  index_t SIZE_IN,
  input  data_t  DATA_IN,
  output data_t  DATA_OUT,
  output index_t INDEX_OUT
);

  ////////////////////////////////////////////////////////////////////////////
  // Signals
  ////////////////////////////////////////////////////////////////////////////

  // FSM
  vec_state_t state;
  // Current element
  index_t     index_loop;

  // Scalar unit handshake
  logic  start_scalar;
  logic  ready_scalar;

  // Scalar operands, latched per element
  data_t modulo_scalar;
  data_t data_in_scalar;
  data_t data_out_scalar;

  // Top reads its input buffer at this index
  assign INDEX_OUT = index_loop;

  ////////////////////////////////////////////////////////////////////////////
  // Control
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state           <= STARTER;
      index_loop      <= '0;
      start_scalar    <= 1'b0;
      READY           <= 1'b0;
      DATA_OUT_ENABLE <= 1'b0;
    end else begin
      // All strobes are single cycle
      start_scalar    <= 1'b0;
      READY           <= 1'b0;
      DATA_OUT_ENABLE <= 1'b0;
      case (state)
        STARTER: begin
          if (START) begin
            index_loop <= '0;
            state      <= INPUT;
          end
        end
        INPUT: begin
          // Wait for the element to be present in the buffer
          if (DATA_IN_ENABLE) begin
            start_scalar <= 1'b1;
            state        <= ENDER;
          end
        end
        ENDER: begin
          if (ready_scalar) begin
            DATA_OUT_ENABLE <= 1'b1;
            if (index_loop == SIZE_IN) begin
              // Last element
              READY <= 1'b1;
              state <= STARTER;
            end else begin
              index_loop <= index_loop + 1'b1;
              state      <= INPUT;
            end
          end
        end
        default: begin
          state <= STARTER;
        end
      endcase
    end
  end

  // Operand capture and result register
  always_ff @(posedge CLK) begin
    if (state == INPUT && DATA_IN_ENABLE) begin
      modulo_scalar  <= MODULO_IN;
      data_in_scalar <= DATA_IN;
    end
    if (state == ENDER && ready_scalar) begin
      DATA_OUT <= data_out_scalar;
    end
  end

  ntm_scalar_cosh_function scalar_cosh_function (
    .CLK       (CLK),
    .RST       (RST),
    .START     (start_scalar),
    .READY     (ready_scalar),
    .MODULO_IN (modulo_scalar),
    .DATA_IN   (data_in_scalar),
    .DATA_OUT  (data_out_scalar)
  );

endmodule

// ==== project.f ====
+incdir+.
ntm_pkg.sv
ntm_mod_multiplier.sv
ntm_integer_divider.sv
ntm_scalar_cosh_function.sv
ntm_vector_cosh_function.sv
ntm_cosh_wb_top.sv
ntm_cosh_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the vector cosh testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module ntm_cosh_tb -f project.f -o ntm_cosh_sim

./obj_dir/ntm_cosh_sim > sim.log
cat sim.log

if grep -q "Done: no errors" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi
